// ==== include/tcdm_settings.svh ====
`ifndef TCDM_SETTINGS_SVH
`define TCDM_SETTINGS_SVH

// masters sharing the memory
`define TCDM_NUM_MASTERS 4
// single ported banks, word interleaved
`define TCDM_NUM_BANKS 8
// word rows held by each bank
`define TCDM_ROW_BITS 4
// memory word width
`define TCDM_DATA_WIDTH 32
// statistics counter width
`define TCDM_CNT_WIDTH 16
// request threshold width
`define TCDM_PROB_WIDTH 8

// derived index widths
`define TCDM_BANK_BITS $clog2(`TCDM_NUM_BANKS)
`define TCDM_MASTER_BITS $clog2(`TCDM_NUM_MASTERS)

`endif

// ==== src/tcdm_pkg.sv ====
`include "tcdm_settings.svh"

package tcdm_pkg;

  ////////////////////////////////////////
  // plain vectors
  ////////////////////////////////////////

  typedef logic [`TCDM_DATA_WIDTH-1:0] data_t;
  typedef logic [`TCDM_BANK_BITS-1:0] bank_idx_t;
  typedef logic [`TCDM_ROW_BITS-1:0] row_addr_t;
  // low bits pick the bank, high bits the row inside it
  typedef logic [`TCDM_ROW_BITS+`TCDM_BANK_BITS-1:0] word_addr_t;
  typedef logic [`TCDM_MASTER_BITS-1:0] master_idx_t;
  typedef logic [`TCDM_CNT_WIDTH-1:0] cnt_t;
  typedef logic [`TCDM_PROB_WIDTH-1:0] prob_t;

  ////////////////////////////////////////
  // enums
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    PAT_UNIFORM  = 2'd0,
    PAT_LINEAR   = 2'd1,
    PAT_CONSTANT = 2'd2
  } pattern_e;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_DRAIN = 2'd2,
    ST_DONE  = 2'd3
  } run_state_e;

  ////////////////////////////////////////
  // bundles
  ////////////////////////////////////////

  typedef struct packed {
    logic       req;
    word_addr_t addr;
  } mst_req_t;

  typedef struct packed {
    logic       valid;
    word_addr_t addr;
    data_t      data;
  } mst_rsp_t;

  typedef struct packed {
    logic       valid;
    word_addr_t addr;
    data_t      data;
  } load_t;

  typedef struct packed {
    cnt_t req_cnt;
    cnt_t gnt_cnt;
    cnt_t wait_cnt;
  } stat_t;

endpackage

// ==== src/tcdm_run_ctrl.sv ====
`timescale 1ns/1ns

module tcdm_run_ctrl (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           start_i,
  input  tcdm_pkg::cnt_t num_cycles_i,
  input  logic           busy_i,
  output logic           gen_en_o,
  output logic           stats_clr_o,
  output logic           done_o
);

  import tcdm_pkg::*;

  run_state_e state_q;
  run_state_e state_d;
  cnt_t       timer_q;
  cnt_t       timer_d;
  logic       launch;

  // start is honoured only when no run is active
  assign launch = start_i && (state_q == ST_IDLE || state_q == ST_DONE);

  always_comb begin
    state_d = state_q;
    timer_d = timer_q;
    unique case (state_q)
      ST_IDLE, ST_DONE: begin
        if (launch) begin
          // timer holds the run cycles still to go
          timer_d = num_cycles_i;
          state_d = (num_cycles_i == '0) ? ST_DRAIN : ST_RUN;
        end
      end
      ST_RUN: begin
        timer_d = timer_q - 1'b1;
        // last run cycle
        if (timer_q <= cnt_t'(1)) begin
          state_d = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        // wait for held requests and reads in flight
        if (!busy_i) begin
          state_d = ST_DONE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      timer_q <= '0;
    end else begin
      state_q <= state_d;
      timer_q <= timer_d;
    end
  end

  assign gen_en_o    = (state_q == ST_RUN);
  // counters clear on the same edge that enters the run
  assign stats_clr_o = launch;
  assign done_o      = (state_q == ST_DONE);

endmodule

// ==== src/tcdm_port_stats.sv ====
`timescale 1ns/1ns
`include "tcdm_settings.svh"

module tcdm_port_stats (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clr_i,
  input  logic [`TCDM_NUM_MASTERS-1:0] req_i,
  input  logic [`TCDM_NUM_MASTERS-1:0] gnt_i,
  input  tcdm_pkg::master_idx_t        sel_i,
  output tcdm_pkg::stat_t              stat_o
);

  import tcdm_pkg::*;

  stat_t cnt_q [`TCDM_NUM_MASTERS];

  // increment that sticks at all ones
  function automatic cnt_t sat_inc(cnt_t val, logic hit);
    cnt_t res;
    res = val;
    if (hit && (val != '1)) begin
      res = val + 1'b1;
    end
    return res;
  endfunction

  ////////////////////////////////////////
  // per master counters
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
        cnt_q[m] <= '0;
      end
    end else begin
      for (int m = 0; m < `TCDM_NUM_MASTERS; m++) begin
        if (clr_i) begin
          cnt_q[m] <= '0;
        end else begin
          // cycles with a request
          cnt_q[m].req_cnt  <= sat_inc(cnt_q[m].req_cnt, req_i[m]);
          cnt_q[m].gnt_cnt  <= sat_inc(cnt_q[m].gnt_cnt, gnt_i[m]);
          // lost arbitration, request held
          cnt_q[m].wait_cnt <= sat_inc(cnt_q[m].wait_cnt, req_i[m] && !gnt_i[m]);
        end
      end
    end
  end

  // readout of one master
  assign stat_o = cnt_q[sel_i];

endmodule

// ==== src/tcdm_traffic_gen.sv ====
`timescale 1ns/1ns
`include "tcdm_settings.svh"

module tcdm_traffic_gen #(
  parameter int unsigned MASTER_ID = 0
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               gen_en_i,
  input  tcdm_pkg::pattern_e pattern_i,
  input  tcdm_pkg::prob_t    req_prob_i,
  input  logic               gnt_i,
  output tcdm_pkg::mst_req_t req_o
);

  import tcdm_pkg::*;

  // nonzero seed per master so the streams differ
  localparam logic [15:0] LFSR_SEED = 16'(MASTER_ID + 1);
  // linear walk interleaves all masters
  localparam word_addr_t LIN_STRIDE = word_addr_t'(`TCDM_NUM_MASTERS);
  localparam word_addr_t LIN_START  = word_addr_t'(MASTER_ID);

  logic [15:0] lfsr_q;
  logic        lfsr_fb;
  word_addr_t  lin_q;
  word_addr_t  draw_addr;
  mst_req_t    pend_q;
  mst_req_t    req_d;

  // fibonacci taps 16 14 13 11
  assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

  ////////////////////////////////////////
  // address for a fresh request
  ////////////////////////////////////////

  always_comb begin
    unique case (pattern_i)
      PAT_LINEAR:   draw_addr = lin_q;
      // hot spot on word 0
      PAT_CONSTANT: draw_addr = '0;
      // upper lfsr bits, kept apart from the threshold byte
      default:      draw_addr = lfsr_q[15 -: $bits(word_addr_t)];
    endcase
  end

  // a held request wins over a new draw
  always_comb begin
    if (pend_q.req) begin
      req_d = pend_q;
    end else begin
      req_d.req  = gen_en_i && (lfsr_q[`TCDM_PROB_WIDTH-1:0] <= req_prob_i);
      req_d.addr = draw_addr;
    end
  end

  assign req_o = req_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= LFSR_SEED;
      lin_q  <= LIN_START;
      pend_q <= '0;
    end else begin
      lfsr_q <= {lfsr_q[14:0], lfsr_fb};
      // walk restarts at every run
      if (!gen_en_i) begin
        lin_q <= LIN_START;
      end else if (gnt_i && (pattern_i == PAT_LINEAR)) begin
        lin_q <= lin_q + LIN_STRIDE;
      end
      // keep an ungranted request for the next cycle
      pend_q.req  <= req_d.req && !gnt_i;
      pend_q.addr <= req_d.addr;
    end
  end

endmodule

// ==== src/tcdm_bank_mem.sv ====
`timescale 1ns/1ns
`include "tcdm_settings.svh"

module tcdm_bank_mem (
  input  logic                clk_i,
  input  logic                cs_i,
  input  tcdm_pkg::row_addr_t row_i,
  input  logic                we_i,
  input  tcdm_pkg::row_addr_t wrow_i,
  input  tcdm_pkg::data_t     wdata_i,
  output tcdm_pkg::data_t     rdata_o
);

  import tcdm_pkg::*;

  localparam int unsigned DEPTH = 2 ** `TCDM_ROW_BITS;

  data_t mem_q [DEPTH];
  data_t rdata_q;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // load port writes, used only while no run is active
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[wrow_i] <= wdata_i;
    end
  end

  // one cycle read, output held when not selected
  always_ff @(posedge clk_i) begin
    if (cs_i) begin
      rdata_q <= mem_q[row_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== src/tcdm_bank_xbar.sv ====
`timescale 1ns/1ns
`include "tcdm_settings.svh"

module tcdm_bank_xbar (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  tcdm_pkg::mst_req_t [`TCDM_NUM_MASTERS-1:0]   req_i,
  output logic [`TCDM_NUM_MASTERS-1:0]                 gnt_o,
  input  tcdm_pkg::load_t                              load_i,
  output tcdm_pkg::mst_rsp_t [`TCDM_NUM_MASTERS-1:0]   rsp_o,
  output logic                                         busy_o
);

  import tcdm_pkg::*;

  localparam int unsigned NM = `TCDM_NUM_MASTERS;
  localparam int unsigned NB = `TCDM_NUM_BANKS;

  logic [NB-1:0][NM-1:0] bank_gnt;
  logic [NM-1:0]         req_vld;
  logic [NM-1:0]         gnt_q;
  word_addr_t            addr_q [NM];
  data_t                 bank_rdata [NB];
  bank_idx_t             load_bank;
  row_addr_t             load_row;

  assign load_bank = load_i.addr[`TCDM_BANK_BITS-1:0];
  assign load_row  = load_i.addr[`TCDM_BANK_BITS +: `TCDM_ROW_BITS];

  ////////////////////////////////////////
  // per bank decode and round robin
  ////////////////////////////////////////

  for (genvar b = 0; b < NB; b++) begin : g_bank
    logic [NM-1:0] hit;
    logic [NM-1:0] win;
    master_idx_t   win_idx;
    master_idx_t   cand;
    master_idx_t   rr_q;
    logic          found;
    logic          we;
    row_addr_t     row;

    for (genvar m = 0; m < NM; m++) begin : g_hit
      assign hit[m] = req_i[m].req && (req_i[m].addr[`TCDM_BANK_BITS-1:0] == bank_idx_t'(b));
    end

    // first requester at or after the pointer
    always_comb begin
      win     = '0;
      win_idx = rr_q;
      found   = 1'b0;
      cand    = rr_q;
      for (int i = 0; i < NM; i++) begin
        cand = master_idx_t'((int'(rr_q) + i) % NM);
        if (!found && hit[cand]) begin
          found     = 1'b1;
          win[cand] = 1'b1;
          win_idx   = cand;
        end
      end
    end

    // pointer moves past the winner, only on a grant
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rr_q <= '0;
      end else if (found) begin
        rr_q <= master_idx_t'((int'(win_idx) + 1) % NM);
      end
    end

    assign row = req_i[win_idx].addr[`TCDM_BANK_BITS +: `TCDM_ROW_BITS];
    assign we  = load_i.valid && (load_bank == bank_idx_t'(b));
    assign bank_gnt[b] = win;

    tcdm_bank_mem bank_mem_inst (
      .clk_i   (clk_i),
      .cs_i    (found),
      .row_i   (row),
      .we_i    (we),
      .wrow_i  (load_row),
      .wdata_i (load_i.data),
      .rdata_o (bank_rdata[b])
    );
  end

  // each master targets one bank, so at most one bit set per master
  always_comb begin
    gnt_o = '0;
    for (int b = 0; b < NB; b++) begin
      gnt_o = gnt_o | bank_gnt[b];
    end
  end

  ////////////////////////////////////////
  // response routing
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt_o;
    end
  end

  // granted address picks the bank whose read data returns
  always_ff @(posedge clk_i) begin
    for (int m = 0; m < NM; m++) begin
      if (gnt_o[m]) begin
        addr_q[m] <= req_i[m].addr;
      end
    end
  end

  always_comb begin
    for (int m = 0; m < NM; m++) begin
      req_vld[m]     = req_i[m].req;
      rsp_o[m].valid = gnt_q[m];
      rsp_o[m].addr  = addr_q[m];
      rsp_o[m].data  = bank_rdata[addr_q[m][`TCDM_BANK_BITS-1:0]];
    end
  end

  // pending requests or reads still in flight
  assign busy_o = (|req_vld) || (|gnt_q);

endmodule

// ==== src/tcdm_traffic_top.sv ====
`timescale 1ns/1ns
`include "tcdm_settings.svh"

module tcdm_traffic_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       start_i,
  input  tcdm_pkg::pattern_e                         pattern_i,
  input  tcdm_pkg::prob_t                            req_prob_i,
  input  tcdm_pkg::cnt_t                             num_cycles_i,
  input  tcdm_pkg::load_t                            load_i,
  input  tcdm_pkg::master_idx_t                      stat_sel_i,
  output logic                                       done_o,
  output tcdm_pkg::mst_rsp_t [`TCDM_NUM_MASTERS-1:0] rsp_o,
  output tcdm_pkg::stat_t                            stat_o
);

  import tcdm_pkg::*;

  logic                                gen_en;
  logic                                stats_clr;
  logic                                busy;
  mst_req_t [`TCDM_NUM_MASTERS-1:0]    mst_req;
  logic [`TCDM_NUM_MASTERS-1:0]        mst_gnt;
  logic [`TCDM_NUM_MASTERS-1:0]        req_vld;

  ////////////////////////////////////////
  // run control
  ////////////////////////////////////////

  tcdm_run_ctrl run_ctrl_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .num_cycles_i (num_cycles_i),
    .busy_i       (busy),
    .gen_en_o     (gen_en),
    .stats_clr_o  (stats_clr),
    .done_o       (done_o)
  );

  // one generator per master
  for (genvar m = 0; m < `TCDM_NUM_MASTERS; m++) begin : g_gen
    tcdm_traffic_gen #(
      .MASTER_ID (m)
    ) traffic_gen_inst (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .gen_en_i   (gen_en),
      .pattern_i  (pattern_i),
      .req_prob_i (req_prob_i),
      .gnt_i      (mst_gnt[m]),
      .req_o      (mst_req[m])
    );
    assign req_vld[m] = mst_req[m].req;
  end

  ////////////////////////////////////////
  // interconnect, banks and statistics
  ////////////////////////////////////////

  tcdm_bank_xbar bank_xbar_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mst_req),
    .gnt_o  (mst_gnt),
    .load_i (load_i),
    .rsp_o  (rsp_o),
    .busy_o (busy)
  );

  tcdm_port_stats port_stats_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .clr_i  (stats_clr),
    .req_i  (req_vld),
    .gnt_i  (mst_gnt),
    .sel_i  (stat_sel_i),
    .stat_o (stat_o)
  );

endmodule

// ==== sim/tcdm_traffic_props.sv ====
`timescale 1ns/1ns
`include "tcdm_settings.svh"

module tcdm_traffic_props (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  tcdm_pkg::mst_req_t [`TCDM_NUM_MASTERS-1:0] req_i,
  input  logic [`TCDM_NUM_MASTERS-1:0]               gnt_i,
  input  tcdm_pkg::mst_rsp_t [`TCDM_NUM_MASTERS-1:0] rsp_i
);

  import tcdm_pkg::*;

  localparam int NM = `TCDM_NUM_MASTERS;

  for (genvar m = 0; m < NM; m++) begin : g_mst
    // read data comes back one cycle after the grant
    a_gnt_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
      gnt_i[m] |=> rsp_i[m].valid)
      else $error("master %0d granted but no response in the next cycle", m);

    // a losing request stays put, same address
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (req_i[m].req && !gnt_i[m]) |=>
        (req_i[m].req && (req_i[m].addr == $past(req_i[m].addr))))
      else $error("master %0d changed an ungranted request", m);

    // never two winners on one bank
    for (genvar n = m + 1; n < NM; n++) begin : g_pair
      a_one_per_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (gnt_i[m] && gnt_i[n]) |->
          (req_i[m].addr[`TCDM_BANK_BITS-1:0] != req_i[n].addr[`TCDM_BANK_BITS-1:0]))
        else $error("masters %0d and %0d granted on the same bank", m, n);
    end
  end

endmodule

bind tcdm_traffic_top tcdm_traffic_props props_inst (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .req_i  (mst_req),
  .gnt_i  (mst_gnt),
  .rsp_i  (rsp_o)
);

// ==== sim/tcdm_traffic_tb.sv ====
`timescale 1ns/1ns
`include "tcdm_settings.svh"

module tcdm_traffic_tb;

  import tcdm_pkg::*;

  localparam int NM           = `TCDM_NUM_MASTERS;
  localparam int NUM_WORDS    = 2 ** $bits(word_addr_t);
  localparam int NUM_ROWS     = 4;
  localparam int CLK_PERIOD   = 20;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 10;
  // slack per row for drain, load and readout
  localparam int DRAIN_SLACK  = 64;
  localparam int LOAD_SLACK   = 200;

  // one table row with its stimulus and what to expect from it
  typedef struct packed {
    pattern_e pat;
    prob_t    prob;
    cnt_t     cycles;
    logic     lin_walk;
    logic     hot_spot;
  } test_row_t;

  logic              clk_i;
  logic              rst_ni;
  logic              start_i;
  pattern_e          pattern_i;
  prob_t             req_prob_i;
  cnt_t              num_cycles_i;
  load_t             load_i;
  master_idx_t       stat_sel_i;
  logic              done_o;
  mst_rsp_t [NM-1:0] rsp_o;
  stat_t             stat_o;

  // copy of what sits in the banks
  data_t     mem_model [NUM_WORDS];
  int        rsp_cnt [NM];
  test_row_t cur_row;
  int        err_cnt;
  int        cycle_cnt;
  integer    seed = 32'hc85b_5aea;

  tcdm_traffic_top tcdm_traffic_top_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (start_i),
    .pattern_i    (pattern_i),
    .req_prob_i   (req_prob_i),
    .num_cycles_i (num_cycles_i),
    .load_i       (load_i),
    .stat_sel_i   (stat_sel_i),
    .done_o       (done_o),
    .rsp_o        (rsp_o),
    .stat_o       (stat_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // test table and helpers
  ////////////////////////////////////////

  function automatic test_row_t test_row(int idx);
    test_row_t r;
    r = '0;
    case (idx)
      0: r = '{PAT_UNIFORM, 8'd255, 16'd200, 1'b0, 1'b0};
      1: r = '{PAT_UNIFORM, 8'd64, 16'd200, 1'b0, 1'b0};
      // strided walk that never shares a bank
      2: r = '{PAT_LINEAR, 8'd255, 16'd200, 1'b1, 1'b0};
      3: r = '{PAT_CONSTANT, 8'd255, 16'd100, 1'b0, 1'b1};
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic int cycle_limit();
    int        total;
    test_row_t r;
    total = RESET_CYCLES;
    for (int i = 0; i < NUM_ROWS; i++) begin
      r = test_row(i);
      total += int'(r.cycles) + DRAIN_SLACK + LOAD_SLACK;
    end
    return total;
  endfunction

  task automatic check_eq(string what, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("[FAIL] t=%0t %s got %0h expected %0h", $time, what, got, exp);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // inputs change a little after the rising edge
  task automatic next_drive();
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  task automatic fill_memory();
    data_t word;
    for (int a = 0; a < NUM_WORDS; a++) begin
      next_drive();
      word = $random(seed);
      mem_model[a] = word;
      load_i = '{valid: 1'b1, addr: word_addr_t'(a), data: word};
    end
    next_drive();
    load_i = '0;
  endtask

  task automatic run_row(test_row_t r);
    stat_t st [NM];
    int    gnt_min;
    int    gnt_max;
    cur_row      = r;
    pattern_i    = r.pat;
    req_prob_i   = r.prob;
    num_cycles_i = r.cycles;
    stat_sel_i   = '0;
    for (int m = 0; m < NM; m++) begin
      rsp_cnt[m] = 0;
    end
    start_i = 1'b1;
    next_drive();
    start_i = 1'b0;
    // launch edge has passed so done and counters read zero
    @(negedge clk_i);
    check_eq("done_o", 32'(done_o), 32'd0);
    check_eq("stat_o.gnt_cnt", 32'(stat_o.gnt_cnt), 32'd0);
    check_eq("stat_o.req_cnt", 32'(stat_o.req_cnt), 32'd0);
    do begin
      @(negedge clk_i);
    end while (!done_o);

    gnt_min = 32'h7fff_ffff;
    gnt_max = 0;
    for (int m = 0; m < NM; m++) begin
      next_drive();
      stat_sel_i = master_idx_t'(m);
      @(negedge clk_i);
      st[m] = stat_o;
      check_eq($sformatf("stat_o[%0d].req_cnt", m), 32'(st[m].req_cnt),
               32'(st[m].gnt_cnt) + 32'(st[m].wait_cnt));
      check_eq($sformatf("rsp_o[%0d] count", m), 32'(rsp_cnt[m]), 32'(st[m].gnt_cnt));
      if (r.lin_walk) begin
        check_eq($sformatf("stat_o[%0d].wait_cnt", m), 32'(st[m].wait_cnt), 32'd0);
        check_eq($sformatf("stat_o[%0d].gnt_cnt", m), 32'(st[m].gnt_cnt), 32'(r.cycles));
      end
      if (int'(st[m].gnt_cnt) < gnt_min) gnt_min = int'(st[m].gnt_cnt);
      if (int'(st[m].gnt_cnt) > gnt_max) gnt_max = int'(st[m].gnt_cnt);
    end
    // round robin keeps the hot spot fair
    if (r.hot_spot) begin
      check_eq("gnt_cnt spread below two", 32'(gnt_max - gnt_min <= 1), 32'd1);
    end
    check_eq("done_o", 32'(done_o), 32'd1);
  endtask

  ////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      for (int m = 0; m < NM; m++) begin
        if (rsp_o[m].valid) begin
          check_eq($sformatf("rsp_o[%0d].data", m), rsp_o[m].data,
                   mem_model[rsp_o[m].addr]);
          // walk is m, m+4, m+8 ... wrapping at the top word
          if (cur_row.lin_walk) begin
            check_eq($sformatf("rsp_o[%0d].addr", m), 32'(rsp_o[m].addr),
                     32'(word_addr_t'(m + NM * rsp_cnt[m])));
          end
          if (cur_row.hot_spot) begin
            check_eq($sformatf("rsp_o[%0d].addr", m), 32'(rsp_o[m].addr), 32'd0);
          end
          rsp_cnt[m]++;
        end
      end
    end
  end

  // hard stop if a run never finishes
  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_cnt > cycle_limit()) begin
        $display("timeout, the runs did not finish within %0d cycles", cycle_limit());
        $display("Testbench failed");
        $fatal(1, "simulation timeout");
      end
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    err_cnt      = 0;
    cur_row      = '0;
    start_i      = 1'b0;
    pattern_i    = PAT_UNIFORM;
    req_prob_i   = '0;
    num_cycles_i = '0;
    load_i       = '0;
    stat_sel_i   = '0;
    rst_ni       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DLY;
    rst_ni = 1'b1;

    for (int i = 0; i < NUM_ROWS; i++) begin
      fill_memory();
      run_row(test_row(i));
    end

    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== tcdm_traffic_top.f ====
+incdir+include
src/tcdm_pkg.sv
src/tcdm_run_ctrl.sv
src/tcdm_port_stats.sv
src/tcdm_traffic_gen.sv
src/tcdm_bank_mem.sv
src/tcdm_bank_xbar.sv
src/tcdm_traffic_top.sv
sim/tcdm_traffic_props.sv
sim/tcdm_traffic_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tcdm_traffic_tb
FILELIST   := tcdm_traffic_top.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
